/* tb/alu_trace.txt */
# columns: group func(decimal) operand1(hex) operand2(hex) tag(decimal) expected(hex)
# groups: 1 functions, 2 idle latency, 3 burst, 4 mixed, 5 tag reuse
1 0 00000005 00000003 0 00000008
1 0 ffffffff 00000001 1 00000000
1 1 00000003 00000005 2 fffffffe
1 1 80000000 00000001 3 7fffffff
1 2 f0f0f0f0 0ff00ff0 4 00f000f0
1 3 f0f0f0f0 0ff00ff0 5 fff0fff0
1 4 f0f0f0f0 0ff00ff0 6 ff00ff00
1 5 ffffffff 00000001 7 00000001
1 6 ffffffff 00000001 0 00000000
1 5 00000001 ffffffff 1 00000000
1 6 00000001 ffffffff 2 00000001
1 5 80000000 7fffffff 3 00000001
1 6 80000000 7fffffff 4 00000000
1 5 00000004 00000004 5 00000000
1 7 00000001 00000004 6 00000010
1 7 00000001 00000024 7 00000010
1 7 12345678 00000020 0 12345678
1 7 80000001 0000001f 1 80000000
1 8 80000000 00000004 2 08000000
1 9 80000000 00000004 3 f8000000
1 8 f0000000 00000021 4 78000000
1 9 f0000000 00000021 5 f8000000
1 9 7ffffff0 00000004 6 07ffffff
1 8 ffffffff 0000003f 7 00000001
1 9 ffffffff 0000003f 0 ffffffff
1 10 12345678 9abcdef0 1 00000000
1 15 ffffffff ffffffff 2 00000000
2 0 00000010 00000020 3 00000030
3 0 00000001 00000001 0 00000002
3 1 00000064 00000001 1 00000063
3 2 0000ffff 00ff00ff 2 000000ff
3 3 00000100 00000001 3 00000101
3 4 aaaaaaaa 55555555 4 ffffffff
3 7 00000003 00000008 5 00000300
3 8 00000300 00000008 6 00000003
3 0 7fffffff 00000001 7 80000000
4 0 00001000 00000234 0 00001234
4 1 00001234 00000234 1 00001000
4 2 ff00ff00 0f0f0f0f 2 0f000f00
4 3 ff00ff00 0f0f0f0f 3 ff0fff0f
4 4 ff00ff00 0f0f0f0f 4 f00ff00f
4 5 fffffffe ffffffff 5 00000001
4 6 fffffffe ffffffff 6 00000001
4 7 0000000f 00000008 7 00000f00
4 8 0000f000 0000000c 0 0000000f
4 9 8000f000 0000000c 1 fff8000f
4 0 ffffff00 00000100 2 00000000
4 1 00000000 00000001 3 ffffffff
4 12 00000001 00000002 4 00000000
4 5 00000000 00000000 5 00000000
4 6 00000000 00000001 6 00000001
4 0 11111111 22222222 7 33333333
4 0 00000007 00000009 0 00000010
4 1 00000010 00000001 1 0000000f
4 7 ffffffff 00000010 2 ffff0000
4 8 ffffffff 00000010 3 0000ffff
4 9 ffff0000 00000010 4 ffffffff
4 3 00000000 00000000 5 00000000
4 4 12345678 12345678 6 00000000
4 2 12345678 ffffffff 7 12345678
4 0 80000000 80000000 0 00000000
5 0 00000001 00000002 3 00000003
5 0 00000003 00000004 3 00000007
5 1 00000009 00000004 3 00000005
5 7 00000003 00000001 3 00000006

/* flist.f */
src/isa_pkg.sv
src/ooo_pkg.sv
src/alu_issue_queue.sv
src/alu.sv
src/cdb_arbiter.sv
src/alu_cluster.sv
tb/alu_cluster_assertions.sv
tb/alu_cluster_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module alu_cluster_tb \
		-f flist.f --Mdir obj_dir -o alu_cluster_sim

run: compile
	./obj_dir/alu_cluster_sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "result: FAIL"; exit 1; \
	elif grep -q "Simulation completed successfully" $(LOG); then \
		echo "result: PASS"; \
	else \
		echo "result: FAIL, run ended early"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tb/alu_cluster_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_cluster_tb import isa_pkg::*, ooo_pkg::*; ();

    localparam int LATENCY = 8; // uut runs at its defaults

    logic      clk_in;
    logic      rst_in;
    logic      dispatch_valid;
    alu_func_e dispatch_func;
    word_t     dispatch_rval1;
    word_t     dispatch_rval2;
    rob_idx_t  dispatch_rob_idx;
    logic      dispatch_ready;
    logic      cdb_valid;
    word_t     cdb_data;
    rob_idx_t  cdb_rob_idx;

    // trace contents by operation
    int       tr_group [$];
    int       tr_func [$];
    word_t    tr_a [$];
    word_t    tr_b [$];
    rob_idx_t tr_tag [$];
    word_t    tr_exp [$];

    // scoreboard by tag
    bit    pending [8];
    word_t exp_data [8];
    int    disp_cycle [8];

    int       cycle = 0;
    int       errors = 0;
    int       tests_passed = 0;
    int       tests_failed = 0;
    int       timeout_limit = 0;
    int       seed = 32'hf6c8_04b7;
    int       sent = 0;
    int       received = 0;
    bit       loaded = 0;
    bit       ready_low_seen;

    alu_cluster uut (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .dispatch_valid   (dispatch_valid),
        .dispatch_func    (dispatch_func),
        .dispatch_rval1   (dispatch_rval1),
        .dispatch_rval2   (dispatch_rval2),
        .dispatch_rob_idx (dispatch_rob_idx),
        .dispatch_ready   (dispatch_ready),
        .cdb_valid        (cdb_valid),
        .cdb_data         (cdb_data),
        .cdb_rob_idx      (cdb_rob_idx)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    always @(negedge clk_in) cycle <= cycle + 1;

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_tag(string name, rob_idx_t exp, rob_idx_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_cycles(string name, int exp, int act);
        if (act != exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    function automatic int pending_total();
        int n;
        n = 0;
        for (int t = 0; t < 8; t++) begin
            n += pending[t];
        end
        return n;
    endfunction

    function automatic string group_name(int g);
        case (g)
            1:       return "function results";
            2:       return "idle latency";
            3:       return "queue full burst";
            4:       return "mixed traffic";
            5:       return "tag reuse";
            default: return "extra group";
        endcase
    endfunction

    task automatic read_trace();
        int    fd;
        int    n;
        int    g;
        int    f;
        int    tg;
        word_t a;
        word_t b;
        word_t e;
        string line;
        fd = $fopen("tb/alu_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file tb/alu_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue; // blank or column notes
            n = $sscanf(line, "%d %d %h %h %d %h", g, f, a, b, tg, e);
            if (n == 6) begin
                tr_group.push_back(g);
                tr_func.push_back(f);
                tr_a.push_back(a);
                tr_b.push_back(b);
                tr_tag.push_back(rob_idx_t'(tg));
                tr_exp.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // called and returns on a falling edge
    task automatic dispatch_op(int idx);
        rob_idx_t tag;
        bit       accepted;
        tag = tr_tag[idx];
        while (pending[tag]) @(negedge clk_in); // tag still in flight
        dispatch_valid   = 1'b1;
        dispatch_func    = alu_func_e'(4'(tr_func[idx]));
        dispatch_rval1   = tr_a[idx];
        dispatch_rval2   = tr_b[idx];
        dispatch_rob_idx = tag;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk_in);
            if (dispatch_ready) accepted = 1'b1;
            else ready_low_seen = 1'b1; // hold the operation
        end
        pending[tag]    = 1'b1;
        exp_data[tag]   = tr_exp[idx];
        disp_cycle[tag] = cycle;
        sent++;
        @(negedge clk_in);
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending_total() != 0) @(negedge clk_in);
    endtask

    task automatic finish_test(string name, int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // cdb monitor sees the values from just before the edge
    initial begin
        forever begin
            @(posedge clk_in);
            if (!rst_in && cdb_valid === 1'b1) begin
                received++;
                if (!pending[cdb_rob_idx]) begin
                    errors++;
                    $display("unexpected broadcast at %0t: tag %0d is not outstanding",
                             $time, cdb_rob_idx);
                end else begin
                    check_word("cdb_data", exp_data[cdb_rob_idx], cdb_data);
                    pending[cdb_rob_idx] = 1'b0;
                end
            end
        end
    end

    initial begin
        wait (loaded);
        wait (cycle > timeout_limit);
        $display("run timed out after %0d cycles", timeout_limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int idx;
        int group;
        int err_before;
        int gap;
        rst_in           = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_func    = alu_add;
        dispatch_rval1   = '0;
        dispatch_rval2   = '0;
        dispatch_rob_idx = '0;
        read_trace();
        timeout_limit = tr_group.size() * (LATENCY + 4) + 200;
        loaded = 1'b1;
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        err_before = errors;
        @(negedge clk_in);
        check_bit("dispatch_ready", 1'b1, dispatch_ready);
        check_bit("cdb_valid", 1'b0, cdb_valid);
        finish_test("reset values", err_before);

        idx = 0;
        while (idx < tr_group.size()) begin
            group          = tr_group[idx];
            err_before     = errors;
            ready_low_seen = 1'b0;
            wait_drain();
            repeat (2) @(negedge clk_in);
            while (idx < tr_group.size() && tr_group[idx] == group) begin
                if (group != 2 && group != 3) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge clk_in);
                end
                dispatch_op(idx);
                idx++;
            end
            if (group == 2) begin
                // broadcast cycle opens LATENCY+1 edges after the dispatch edge
                while (cdb_valid !== 1'b1) @(negedge clk_in);
                check_tag("cdb_rob_idx", tr_tag[idx-1], cdb_rob_idx);
                check_cycles("dispatch to cdb edges", LATENCY + 1,
                             cycle - disp_cycle[tr_tag[idx-1]]);
            end
            wait_drain();
            if (group == 3 && !ready_low_seen) begin
                errors++;
                $display("dispatch_ready never dropped during the burst");
            end
            finish_test(group_name(group), err_before);
        end

        err_before = errors;
        repeat (LATENCY + 4) @(negedge clk_in); // catch late duplicates
        if (sent != received) begin
            errors++;
            $display("%0d operations dispatched but %0d broadcasts seen", sent, received);
        end
        finish_test("scoreboard drain", err_before);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0 && tr_group.size() > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/alu_cluster_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_cluster_assertions import isa_pkg::*, ooo_pkg::*; #(
    parameter int NUM_ALU     = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input wire                      clk_in,
    input wire                      rst_in,
    input wire [NUM_ALU-1:0]        issue_valid,
    input wire [NUM_ALU-1:0]        alu_ready,
    input wire [NUM_ALU-1:0]        read,
    input wire                      cdb_valid,
    input wire                      dispatch_ready,
    input wire [$clog2(QUEUE_DEPTH):0] count
);

    // start pulse only into an idle alu
    for (genvar k = 0; k < NUM_ALU; k++) begin : g_issue
        assert property (@(posedge clk_in) disable iff (rst_in)
            issue_valid[k] |-> alu_ready[k])
            else $error("issue pulse to alu %0d while it is not ready", k);
    end

    // one broadcast, one read pulse
    assert property (@(posedge clk_in) disable iff (rst_in)
        cdb_valid == $onehot(read))
        else $error("cdb_valid does not match exactly one read pulse");

    assert property (@(posedge clk_in) disable iff (rst_in)
        (count < QUEUE_DEPTH) |-> dispatch_ready)
        else $error("dispatch_ready low with free queue entries");

endmodule

bind alu_cluster alu_cluster_assertions #(
    .NUM_ALU     (NUM_ALU),
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_assertions (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .issue_valid    (issue_valid),
    .alu_ready      (alu_ready),
    .read           (read),
    .cdb_valid      (cdb_valid),
    .dispatch_ready (dispatch_ready),
    .count          (u_queue.count)
);

`default_nettype wire

/* src/alu_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_cluster import isa_pkg::*, ooo_pkg::*; #(
    parameter int NUM_ALU     = 2,
    parameter int LATENCY     = 8, // at least 2
    parameter int QUEUE_DEPTH = 4  // power of two
) (
    input  wire           clk_in,
    input  wire           rst_in,

    // dispatch side
    input  wire           dispatch_valid,
    input  wire alu_func_e dispatch_func,
    input  wire word_t    dispatch_rval1,
    input  wire word_t    dispatch_rval2,
    input  wire rob_idx_t dispatch_rob_idx,
    output logic          dispatch_ready,

    // common data bus
    output logic          cdb_valid,
    output word_t         cdb_data,
    output rob_idx_t      cdb_rob_idx
);

    // queue to alus
    logic [NUM_ALU-1:0] issue_valid;
    logic [NUM_ALU-1:0] alu_ready;
    alu_func_e          issue_func;
    word_t              issue_rval1;
    word_t              issue_rval2;
    rob_idx_t           issue_rob_idx;

    // alus to arbiter
    logic [NUM_ALU-1:0] result_valid;
    logic [NUM_ALU-1:0] read;
    word_t              result_data [NUM_ALU];
    rob_idx_t           result_rob_idx [NUM_ALU];

    alu_issue_queue #(
        .NUM_ALU     (NUM_ALU),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .dispatch_valid   (dispatch_valid),
        .dispatch_func    (dispatch_func),
        .dispatch_rval1   (dispatch_rval1),
        .dispatch_rval2   (dispatch_rval2),
        .dispatch_rob_idx (dispatch_rob_idx),
        .alu_ready        (alu_ready),
        .dispatch_ready   (dispatch_ready),
        .issue_valid      (issue_valid),
        .issue_func       (issue_func),
        .issue_rval1      (issue_rval1),
        .issue_rval2      (issue_rval2),
        .issue_rob_idx    (issue_rob_idx)
    );

    // shared issue buses, one start pulse per alu
    for (genvar k = 0; k < NUM_ALU; k++) begin : g_alu
        alu #(
            .LATENCY (LATENCY)
        ) u_alu (
            .clk_in      (clk_in),
            .rst_in      (rst_in),
            .valid_in    (issue_valid[k]),
            .read_in     (read[k]),
            .func_in     (issue_func),
            .rval1_in    (issue_rval1),
            .rval2_in    (issue_rval2),
            .rob_idx_in  (issue_rob_idx),
            .data_out    (result_data[k]),
            .rob_idx_out (result_rob_idx[k]),
            .ready_out   (alu_ready[k]),
            .valid_out   (result_valid[k])
        );
    end

    cdb_arbiter #(
        .NUM_ALU (NUM_ALU)
    ) u_arbiter (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .result_valid   (result_valid),
        .result_data    (result_data),
        .result_rob_idx (result_rob_idx),
        .read           (read),
        .cdb_valid      (cdb_valid),
        .cdb_data       (cdb_data),
        .cdb_rob_idx    (cdb_rob_idx)
    );

endmodule

`default_nettype wire

/* src/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter import isa_pkg::*, ooo_pkg::*; #(
    parameter int NUM_ALU = 2
) (
    input  wire                clk_in,
    input  wire                rst_in,
    input  wire [NUM_ALU-1:0]  result_valid,
    input  wire word_t         result_data [NUM_ALU],
    input  wire rob_idx_t      result_rob_idx [NUM_ALU],

    output logic [NUM_ALU-1:0] read,
    output logic               cdb_valid,
    output word_t              cdb_data,
    output rob_idx_t           cdb_rob_idx
);

    localparam int PTR_W = (NUM_ALU > 1) ? $clog2(NUM_ALU) : 1;

    logic [PTR_W-1:0] ptr;   // first alu to look at
    logic [PTR_W-1:0] grant;
    logic             found;

    // search from ptr upward with wrap
    always_comb begin
        int idx;
        found = 1'b0;
        grant = ptr;
        for (int i = 0; i < NUM_ALU; i++) begin
            idx = int'(ptr) + i;
            if (idx >= NUM_ALU) begin
                idx = idx - NUM_ALU;
            end
            if (result_valid[idx] && !found) begin
                found = 1'b1;
                grant = PTR_W'(idx);
            end
        end
    end

    always_comb begin
        read = '0;
        read[grant] = found; // read pulse in the broadcast cycle
    end

    assign cdb_valid   = found;
    assign cdb_data    = result_data[grant];
    assign cdb_rob_idx = result_rob_idx[grant];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ptr <= '0;
        end else if (found) begin
            // next search starts just past the winner
            ptr <= (grant == PTR_W'(NUM_ALU - 1)) ? '0 : grant + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import isa_pkg::*, ooo_pkg::*; #(
    parameter int LATENCY = 8
) (
    input  wire           clk_in,
    input  wire           rst_in,
    input  wire           valid_in, // one-cycle start
    input  wire           read_in,  // one-cycle read from the cdb arbiter
    input  wire alu_func_e func_in,
    input  wire word_t    rval1_in,
    input  wire word_t    rval2_in,
    input  wire rob_idx_t rob_idx_in,

    output word_t         data_out,
    output rob_idx_t      rob_idx_out,
    output logic          ready_out,
    output logic          valid_out  // held until read
);

    localparam int CNT_W = $clog2(LATENCY);

    alu_state_e       state;
    logic [CNT_W-1:0] cnt;

    // latched operation
    alu_func_e func_q;
    word_t     a_q;
    word_t     b_q;

    word_t      calc;
    logic [4:0] shamt;
    logic       take;
    logic       finish;

    assign take   = (state == alu_idle) && valid_in;
    assign finish = (state == alu_busy) && (cnt == '0);

    assign ready_out = (state == alu_idle);
    assign valid_out = (state == alu_done);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= alu_idle;
            cnt   <= '0;
        end else begin
            case (state)
                alu_idle: begin
                    if (valid_in) begin
                        state <= alu_busy;
                        cnt   <= CNT_W'(LATENCY - 1); // done after LATENCY edges
                    end
                end
                alu_busy: begin
                    if (cnt == '0) begin
                        state <= alu_done;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                alu_done: begin
                    if (read_in) begin
                        state <= alu_idle;
                    end
                end
                default: state <= alu_idle;
            endcase
        end
    end

    // operands and tag at issue, result once at the end
    always_ff @(posedge clk_in) begin
        if (take) begin
            func_q      <= func_in;
            a_q         <= rval1_in;
            b_q         <= rval2_in;
            rob_idx_out <= rob_idx_in;
        end
        if (finish) begin
            data_out <= calc;
        end
    end

    assign shamt = b_q[4:0]; // only the low five bits shift

    always_comb begin
        case (func_q)
            alu_add:  calc = a_q + b_q;
            alu_sub:  calc = a_q - b_q;
            alu_and:  calc = a_q & b_q;
            alu_or:   calc = a_q | b_q;
            alu_xor:  calc = a_q ^ b_q;
            alu_slt:  calc = {31'd0, ($signed(a_q) < $signed(b_q))};
            alu_sltu: calc = {31'd0, (a_q < b_q)};
            alu_sll:  calc = a_q << shamt;
            alu_srl:  calc = a_q >> shamt;            // zero fill
            alu_sra:  calc = $signed(a_q) >>> shamt;  // sign fill
            default:  calc = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/alu_issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_issue_queue import isa_pkg::*, ooo_pkg::*; #(
    parameter int NUM_ALU     = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                clk_in,
    input  wire                rst_in,

    input  wire                dispatch_valid,
    input  wire alu_func_e     dispatch_func,
    input  wire word_t         dispatch_rval1,
    input  wire word_t         dispatch_rval2,
    input  wire rob_idx_t      dispatch_rob_idx,
    input  wire [NUM_ALU-1:0]  alu_ready,

    output logic               dispatch_ready,
    output logic [NUM_ALU-1:0] issue_valid,
    output alu_func_e          issue_func,
    output word_t              issue_rval1,
    output word_t              issue_rval2,
    output rob_idx_t           issue_rob_idx
);

    // depth is a power of two so the pointers wrap on their own
    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    // entry storage
    alu_func_e func_mem  [QUEUE_DEPTH];
    word_t     rval1_mem [QUEUE_DEPTH];
    word_t     rval2_mem [QUEUE_DEPTH];
    rob_idx_t  rob_mem   [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count; // one extra bit to tell full from empty

    logic enq;
    logic pop;
    logic found;

    assign dispatch_ready = (count != (PTR_W+1)'(QUEUE_DEPTH));
    assign enq = dispatch_valid && dispatch_ready;

    // head goes to the lowest-numbered ready alu
    always_comb begin
        found = 1'b0;
        issue_valid = '0;
        if (count != '0) begin
            for (int k = 0; k < NUM_ALU; k++) begin
                if (alu_ready[k] && !found) begin
                    issue_valid[k] = 1'b1;
                    found = 1'b1;
                end
            end
        end
    end

    assign pop = found;

    // head entry straight from storage
    assign issue_func    = func_mem[rd_ptr];
    assign issue_rval1   = rval1_mem[rd_ptr];
    assign issue_rval2   = rval2_mem[rd_ptr];
    assign issue_rob_idx = rob_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (enq) begin
            func_mem[wr_ptr]  <= dispatch_func;
            rval1_mem[wr_ptr] <= dispatch_rval1;
            rval2_mem[wr_ptr] <= dispatch_rval2;
            rob_mem[wr_ptr]   <= dispatch_rob_idx;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/ooo_pkg.sv */
`default_nettype none

// out-of-order bookkeeping view
package ooo_pkg;

    // reorder buffer tag, 8 entries
    typedef logic [2:0] rob_idx_t;

    // per-alu state machine
    typedef enum logic [1:0] {
        alu_idle = 2'd0, // ready for an issue
        alu_busy = 2'd1, // counting down latency
        alu_done = 2'd2  // result held until read
    } alu_state_e;

endpackage

`default_nettype wire

/* src/isa_pkg.sv */
`default_nettype none

// instruction-set view of the execution cluster
package isa_pkg;

    // operand and result value
    typedef logic [31:0] word_t;

    // alu function codes, 4 bits wide
    // codes 10 to 15 are unused and give zero
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5, // signed less-than
        alu_sltu = 4'd6, // unsigned less-than
        alu_sll  = 4'd7,
        alu_srl  = 4'd8, // logical
        alu_sra  = 4'd9  // arithmetic
    } alu_func_e;

endpackage

`default_nettype wire
